// File: logic/bullet_pool.sv
`timescale 1ns/1ps
`include "tank_cfg.svh"

module bullet_pool import tank_pkg::*; import shot_pkg::*; (
	input  logic        Reset,
	input  logic        frame_clk,
	input  logic        spawn_valid,
	input  shot_req_t   spawn,
	output logic        spawn_ready,
	input  tank_state_t tank0,
	input  tank_state_t tank1,
	output bullet_t     bullets [`SLOT_NUM],
	output logic [1:0]  hit,
	output logic [3:0]  live_count
);

	logic [`SLOT_NUM-1:0] live_q;
	logic [`SLOT_NUM-1:0] take_v;   // slot receives the new shot
	logic [`SLOT_NUM-1:0] gone_v;   // next step leaves the field
	logic [`SLOT_NUM-1:0] hit0_v;
	logic [`SLOT_NUM-1:0] hit1_v;
	shot_req_t            pos_q [`SLOT_NUM];
	shot_req_t            pos_d [`SLOT_NUM];
	slot_idx_t            free_idx;
	logic                 spawn_fire;

	function automatic logic in_box(logic [10:0] px, logic [10:0] py, tank_state_t t);
		logic [10:0] tx;
		logic [10:0] ty;
		tx = {1'b0, t.x};
		ty = {1'b0, t.y};
		return px >= tx && px < tx + 11'(`TANK_SIZE) &&
			py >= ty && py < ty + 11'(`TANK_SIZE);
	endfunction

	assign spawn_ready = ~&live_q;
	assign spawn_fire  = spawn_valid && spawn_ready;

	// lowest dead slot
	always_comb begin
		free_idx = '0;
		for (int i = `SLOT_NUM - 1; i >= 0; i--) begin
			if (!live_q[i]) free_idx = slot_idx_t'(i);
		end
	end

	// --------------------------------------------------
	// per slot step, edge and box tests
	// --------------------------------------------------
	for (genvar i = 0; i < `SLOT_NUM; i++) begin : g_slot
		logic [10:0] nx;  // one bit wider so -1 lands off field
		logic [10:0] ny;

		always_comb begin
			case (pos_q[i].dir)
				DIR_UL, DIR_LEFT, DIR_DL:  nx = {1'b0, pos_q[i].x} - 11'd1;
				DIR_DR, DIR_RIGHT, DIR_UR: nx = {1'b0, pos_q[i].x} + 11'd1;
				default:                   nx = {1'b0, pos_q[i].x};
			endcase
			case (pos_q[i].dir)
				DIR_UR, DIR_UP, DIR_UL:   ny = {1'b0, pos_q[i].y} - 11'd1;
				DIR_DL, DIR_DOWN, DIR_DR: ny = {1'b0, pos_q[i].y} + 11'd1;
				default:                  ny = {1'b0, pos_q[i].y};
			endcase
		end

		assign pos_d[i]  = '{x: nx[9:0], y: ny[9:0], dir: pos_q[i].dir};
		assign take_v[i] = spawn_fire && free_idx == slot_idx_t'(i);
		assign gone_v[i] = nx >= 11'(`FIELD_W) || ny >= 11'(`FIELD_H);
		assign hit0_v[i] = live_q[i] && in_box(nx, ny, tank0);
		assign hit1_v[i] = live_q[i] && in_box(nx, ny, tank1);

		assign bullets[i] = '{live: live_q[i], dir: pos_q[i].dir, x: pos_q[i].x, y: pos_q[i].y};
	end

	always_comb begin
		live_count = '0;
		for (int i = 0; i < `SLOT_NUM; i++) begin
			live_count = live_count + {3'b000, live_q[i]};
		end
	end

	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			live_q <= '0;
			hit    <= '0;
		end else begin
			for (int i = 0; i < `SLOT_NUM; i++) begin
				if (take_v[i]) live_q[i] <= 1'b1;
				else if (gone_v[i] || hit0_v[i] || hit1_v[i]) live_q[i] <= 1'b0;
			end
			hit <= {|hit1_v, |hit0_v};  // one frame pulse
		end
	end

	// positions step every frame and dead slots just drift
	always_ff @(posedge Reset) begin
		for (int i = 0; i < `SLOT_NUM; i++) begin
			pos_q[i] <= take_v[i] ? spawn : pos_d[i];
		end
	end

	// at most one spawn lands per frame
	a_count_step: assert property (@(posedge Reset) disable iff (frame_clk)
		live_count <= $past(live_count) + 4'd1);

endmodule

// File: logic/shot_arbiter.sv
`timescale 1ns/1ps

module shot_arbiter import tank_pkg::*; (
	input  logic       Reset,
	input  logic       frame_clk,
	input  logic [1:0] req_valid,
	input  shot_req_t  req [2],
	output logic [1:0] req_ready,
	output logic       pool_valid,
	output shot_req_t  pool_shot,
	input  logic       pool_ready
);

	logic prio_q;  // tank that wins a tie
	logic pick;    // tank currently offered to the pool

	// a lone request wins outright and a tie goes to prio_q
	assign pick = (req_valid[0] && req_valid[1]) ? prio_q : req_valid[1];

	assign pool_valid = |req_valid;
	assign pool_shot  = req[pick];

	// ready reaches only the picked tank while the other one holds
	assign req_ready[0] = pool_ready && !pick;
	assign req_ready[1] = pool_ready && pick;

	// --------------------------------------------------
	// round robin with the winner dropping to low priority
	// --------------------------------------------------
	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			prio_q <= 1'b0;
		end else if (pool_valid && pool_ready) begin
			prio_q <= !pick;
		end
	end

	// the tank that waited through a tie is served next
	a_loser_next: assert property (@(posedge Reset) disable iff (frame_clk)
		req_valid == 2'b11 && pool_ready |=> pick != $past(pick));

endmodule

// File: logic/shot_pkg.sv
`include "tank_cfg.svh"

package shot_pkg;
	import tank_pkg::*;

	// --------------------------------------------------
	// direction codes, shared by turret and bullets
	// --------------------------------------------------
	localparam dir_t DIR_UP    = 3'd0;
	localparam dir_t DIR_UL    = 3'd1;  // up left
	localparam dir_t DIR_LEFT  = 3'd2;
	localparam dir_t DIR_DL    = 3'd3;  // down left
	localparam dir_t DIR_DOWN  = 3'd4;
	localparam dir_t DIR_DR    = 3'd5;  // down right
	localparam dir_t DIR_RIGHT = 3'd6;
	localparam dir_t DIR_UR    = 3'd7;  // up right

	typedef logic [$clog2(`SLOT_NUM)-1:0] slot_idx_t;

	// one slot of the shared pool
	typedef struct packed {
		logic   live;
		dir_t   dir;
		coord_t x;
		coord_t y;
	} bullet_t;

endpackage

// File: logic/tank_arena_top.sv
`timescale 1ns/1ps
`include "tank_cfg.svh"

module tank_arena_top import tank_pkg::*; import shot_pkg::*; (
	input  logic        Reset,
	input  logic        frame_clk,
	input  tank_keys_t  keys0,
	input  tank_keys_t  keys1,
	output tank_state_t tank0,
	output tank_state_t tank1,
	output bullet_t     bullets [`SLOT_NUM],
	output logic [1:0]  hit,
	output logic [3:0]  live_count
);

	logic [1:0] shot_valid;
	logic [1:0] shot_ready;
	shot_req_t  shots [2];
	logic       pool_valid;
	logic       pool_ready;
	shot_req_t  pool_shot;

	// --------------------------------------------------
	// two peer tanks sharing one bullet pool
	// --------------------------------------------------
	tank_motion #(.start_x(10'(`TANK0_X0)), .start_y(10'(`TANK0_Y0))) u_tank0 (
		.Reset(Reset), .frame_clk(frame_clk), .keys(keys0), .state(tank0),
		.shot_valid(shot_valid[0]), .shot(shots[0]), .shot_ready(shot_ready[0])
	);

	tank_motion #(.start_x(10'(`TANK1_X0)), .start_y(10'(`TANK1_Y0))) u_tank1 (
		.Reset(Reset), .frame_clk(frame_clk), .keys(keys1), .state(tank1),
		.shot_valid(shot_valid[1]), .shot(shots[1]), .shot_ready(shot_ready[1])
	);

	shot_arbiter u_arb (
		.Reset(Reset), .frame_clk(frame_clk),
		.req_valid(shot_valid), .req(shots), .req_ready(shot_ready),
		.pool_valid(pool_valid), .pool_shot(pool_shot), .pool_ready(pool_ready)
	);

	bullet_pool u_pool (
		.Reset(Reset), .frame_clk(frame_clk),
		.spawn_valid(pool_valid), .spawn(pool_shot), .spawn_ready(pool_ready),
		.tank0(tank0), .tank1(tank1),
		.bullets(bullets), .hit(hit), .live_count(live_count)
	);

endmodule

// File: logic/tank_cfg.svh
`ifndef TANK_CFG_SVH
`define TANK_CFG_SVH

// --------------------------------------------------
// playfield and tank geometry
// --------------------------------------------------
`define FIELD_W        640   // pixels
`define FIELD_H        480
`define TANK_SIZE      32    // square tank box

// start positions, top left corner of the box
`define TANK0_X0       200
`define TANK0_Y0       200
`define TANK1_X0       400
`define TANK1_Y0       400

// --------------------------------------------------
// shots
// --------------------------------------------------
`define SLOT_NUM       8     // shared bullet slots
`define FIRE_PERIOD    16    // frames, power of two
`define TURRET_STEP    7     // angle accumulator width, top 3 bits = direction

`endif

// File: logic/tank_motion.sv
`timescale 1ns/1ps
`include "tank_cfg.svh"

module tank_motion import tank_pkg::*; import shot_pkg::*; #(
	parameter coord_t start_x = 10'd0,
	parameter coord_t start_y = 10'd0
) (
	input  logic        Reset,
	input  logic        frame_clk,
	input  tank_keys_t  keys,
	output tank_state_t state,
	output logic        shot_valid,
	output shot_req_t   shot,
	input  logic        shot_ready
);

	logic [`TURRET_STEP-1:0]         angle_q;  // slow turret rotation
	logic [$clog2(`FIRE_PERIOD)-1:0] cool_q;   // free running cooldown
	logic                            armed_q;
	logic                            fire_key;
	logic                            form;
	dir_t                            turret_dir;
	tank_state_t                     next;
	shot_req_t                       spawn;

	assign turret_dir = angle_q[`TURRET_STEP-1 -: 3];
	assign fire_key   = keys.turret_key == TURRET_FIRE;
	// new request only at a cooldown wrap and never on top of a pending one
	assign form       = !shot_valid && cool_q == '0 && (armed_q || fire_key);

	// --------------------------------------------------
	// base movement, box clamped to the field
	// --------------------------------------------------
	always_comb begin
		next = state;
		case (keys.move_key)
			MOVE_LEFT: begin
				if (state.x != '0) next.x = state.x - 10'd1;
				next.base_dir = DIR_LEFT;
			end
			MOVE_DOWN: begin
				if (state.y < 10'(`FIELD_H - `TANK_SIZE)) next.y = state.y + 10'd1;
				next.base_dir = DIR_DOWN;
			end
			MOVE_UP: begin
				if (state.y != '0) next.y = state.y - 10'd1;
				next.base_dir = DIR_UP;
			end
			MOVE_RIGHT: begin
				if (state.x < 10'(`FIELD_W - `TANK_SIZE)) next.x = state.x + 10'd1;
				next.base_dir = DIR_RIGHT;
			end
			default: ;
		endcase
	end

	// spawn point on the turret side of the box
	always_comb begin
		spawn.dir = turret_dir;
		case (turret_dir)
			DIR_UL, DIR_LEFT, DIR_DL: spawn.x = state.x - 10'd1;
			DIR_UP, DIR_DOWN:         spawn.x = state.x + 10'(`TANK_SIZE / 2);
			default:                  spawn.x = state.x + 10'(`TANK_SIZE);
		endcase
		case (turret_dir)
			DIR_UR, DIR_UP, DIR_UL: spawn.y = state.y - 10'd1;
			DIR_LEFT, DIR_RIGHT:    spawn.y = state.y + 10'(`TANK_SIZE / 2);
			default:                spawn.y = state.y + 10'(`TANK_SIZE);
		endcase
	end

	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			state      <= '{x: start_x, y: start_y, base_dir: DIR_UP};
			angle_q    <= '0;
			cool_q     <= '0;
			armed_q    <= 1'b0;
			shot_valid <= 1'b0;
		end else begin
			state  <= next;
			cool_q <= cool_q + 1'b1;  // wraps every FIRE_PERIOD frames
			case (keys.turret_key)
				TURRET_UP:   angle_q <= angle_q + 1'b1;
				TURRET_DOWN: angle_q <= angle_q - 1'b1;
				default: ;
			endcase
			if (form) armed_q <= 1'b0;
			else if (fire_key) armed_q <= 1'b1;
			if (shot_valid && shot_ready) shot_valid <= 1'b0;
			else if (form) shot_valid <= 1'b1;
		end
	end

	// request payload, held until accepted
	always_ff @(posedge Reset) begin
		if (form) shot <= spawn;
	end

	a_shot_held: assert property (@(posedge Reset) disable iff (frame_clk)
		shot_valid && !shot_ready |=> shot_valid && $stable(shot));

endmodule

// File: logic/tank_pkg.sv
package tank_pkg;

	typedef logic [9:0] coord_t;  // pixel coordinate
	typedef logic [2:0] dir_t;    // 0 up, counter-clockwise in 45 deg steps

	// move key byte
	localparam logic [7:0] MOVE_LEFT  = 8'd1;
	localparam logic [7:0] MOVE_DOWN  = 8'd2;
	localparam logic [7:0] MOVE_UP    = 8'd3;
	localparam logic [7:0] MOVE_RIGHT = 8'd4;

	// turret key byte
	localparam logic [7:0] TURRET_UP   = 8'd1;
	localparam logic [7:0] TURRET_DOWN = 8'd2;
	localparam logic [7:0] TURRET_FIRE = 8'd3;

	typedef struct packed {
		logic [7:0] move_key;
		logic [7:0] turret_key;
	} tank_keys_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		dir_t   base_dir;
	} tank_state_t;

	typedef struct packed {
		coord_t x;    // spawn point, just outside the tank box
		coord_t y;
		dir_t   dir;
	} shot_req_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the tank arena testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tank_arena_tb -o tank_arena_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tank_arena_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	echo "simulation failed"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0

// File: src.f
+incdir+logic
logic/tank_pkg.sv
logic/shot_pkg.sv
logic/tank_motion.sv
logic/shot_arbiter.sv
logic/bullet_pool.sv
logic/tank_arena_top.sv
tests/tank_arena_tb.sv

// File: tests/tank_arena_tb.sv
`timescale 1ns/1ps
`include "tank_cfg.svh"

module tank_arena_tb import tank_pkg::*; import shot_pkg::*; ();

	localparam int HALF_PERIOD  = 20;  // 40 ns frame
	localparam int RESET_CYCLES = 10;

	// one frame of keys and what must hold after it
	typedef struct packed {
		tank_keys_t  keys0;
		tank_keys_t  keys1;
		logic        check;  // set on the last frame of a group
		tank_state_t exp0;
		tank_state_t exp1;
		logic [1:0]  exp_hit;
		logic [3:0]  exp_count;
		slot_idx_t   slot;
		bullet_t     exp_bullet;
	} frame_t;

	logic        Reset;
	logic        frame_clk;
	tank_keys_t  keys0;
	tank_keys_t  keys1;
	tank_state_t tank0;
	tank_state_t tank1;
	bullet_t     bullets [`SLOT_NUM];
	logic [1:0]  hit;
	logic [3:0]  live_count;
	frame_t      frames [$];
	longint      limit_ns = 0;

	tank_arena_top dut (
		.Reset(Reset), .frame_clk(frame_clk), .keys0(keys0), .keys1(keys1),
		.tank0(tank0), .tank1(tank1), .bullets(bullets), .hit(hit), .live_count(live_count)
	);

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic compare_tank(string name, tank_state_t got, tank_state_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s = (%0d,%0d,%0d), expected (%0d,%0d,%0d)", $time, name,
				got.x, got.y, got.base_dir, exp.x, exp.y, exp.base_dir);
			stop_run("tank state mismatch");
		end
	endtask

	task automatic compare_hit(logic [1:0] got, logic [1:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: hit = %b, expected %b", $time, got, exp);
			stop_run("hit flag mismatch");
		end
	endtask

	task automatic compare_count(logic [3:0] got, logic [3:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: live_count = %0d, expected %0d", $time, got, exp);
			stop_run("live count mismatch");
		end
	endtask

	task automatic compare_bullet(string name, bullet_t got, bullet_t exp);
		if (got.live !== exp.live || (exp.live && got !== exp)) begin  // dead slots keep junk
			$display("Error at %0t ns: %s = (%b,%0d,%0d,%0d), expected (%b,%0d,%0d,%0d)",
				$time, name, got.live, got.dir, got.x, got.y, exp.live, exp.dir, exp.x, exp.y);
			stop_run("bullet slot mismatch");
		end
	endtask

	task automatic check_frame(frame_t fr);
		compare_tank("tank0", tank0, fr.exp0);
		compare_tank("tank1", tank1, fr.exp1);
		compare_hit(hit, fr.exp_hit);
		compare_count(live_count, fr.exp_count);
		compare_bullet($sformatf("bullets[%0d]", fr.slot), bullets[fr.slot], fr.exp_bullet);
	endtask

	// each data line is a group of frames with the same keys
	task automatic load_frames();
		int     fd;
		int     n;
		int     cnt, k0, k1, x0, y0, d0, x1, y1, d1, h, c, s, bl, bd, bx, by;
		string  line;
		frame_t fr;
		fd = $fopen("tests/tank_arena_tests.dat", "r");
		if (fd == 0) stop_run("cannot open tests/tank_arena_tests.dat");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") continue;
			n = $sscanf(line, "%d %h %h %d %d %d %d %d %d %b %d %d %d %d %d %d",
				cnt, k0, k1, x0, y0, d0, x1, y1, d1, h, c, s, bl, bd, bx, by);
			if (n != 16 || cnt < 1) stop_run($sformatf("malformed test line: %s", line));
			fr.keys0      = tank_keys_t'(k0[15:0]);
			fr.keys1      = tank_keys_t'(k1[15:0]);
			fr.exp0       = '{x: coord_t'(x0), y: coord_t'(y0), base_dir: dir_t'(d0)};
			fr.exp1       = '{x: coord_t'(x1), y: coord_t'(y1), base_dir: dir_t'(d1)};
			fr.exp_hit    = h[1:0];
			fr.exp_count  = c[3:0];
			fr.slot       = slot_idx_t'(s);
			fr.exp_bullet = '{live: bl[0], dir: dir_t'(bd), x: coord_t'(bx), y: coord_t'(by)};
			for (int i = 0; i < cnt; i++) begin
				fr.check = (i == cnt - 1);
				frames.push_back(fr);
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_frame(int idx);
		if (idx < frames.size()) begin
			keys0 <= frames[idx].keys0;
			keys1 <= frames[idx].keys1;
		end else begin
			keys0 <= '0;
			keys1 <= '0;
		end
	endtask

	initial begin
		Reset = 1'b0;
		forever #HALF_PERIOD Reset = ~Reset;
	end

	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		stop_run("timeout, the frame sequence did not complete");
	end

	initial begin
		int gap;
		frame_clk = 1'b1;
		keys0     = '0;
		keys1     = '0;
		void'($urandom(32'h10cd));
		load_frames();
		gap      = ($urandom % 3) * `FIRE_PERIOD;  // whole periods keep the cooldown phase
		limit_ns = longint'(frames.size() + gap + RESET_CYCLES + 20) * 2 * HALF_PERIOD;
		repeat (RESET_CYCLES) @(posedge Reset);
		frame_clk <= 1'b0;
		repeat (gap) @(posedge Reset);
		@(posedge Reset);
		apply_frame(0);
		for (int i = 0; i < frames.size(); i++) begin
			@(posedge Reset);
			apply_frame(i + 1);
			@(negedge Reset);  // outputs settled after the frame edge
			if (frames[i].check) check_frame(frames[i]);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: tests/tank_arena_tests.dat
# frames keys0 keys1 | tank0 x y dir | tank1 x y dir | hit cnt | slot live dir x y
# keys hex {move,turret}, hit binary {tank1,tank0}, rest decimal, checked after the last frame
1   0400 0000  201 200 6  400 400 0  00 0  0 0 0 0 0
1   0100 0000  200 200 2  400 400 0  00 0  0 0 0 0 0
1   0200 0000  200 201 4  400 400 0  00 0  0 0 0 0 0
1   0300 0000  200 200 0  400 400 0  00 0  0 0 0 0 0
16  0001 0400  200 200 0  416 400 6  00 0  0 0 0 0 0
1   0003 0400  200 200 0  417 400 6  00 0  0 0 0 0 0
11  0000 0400  200 200 0  428 400 6  00 0  0 0 0 0 0
1   0000 0400  200 200 0  429 400 6  00 1  0 1 1 199 199
199 0000 0400  200 200 0  608 400 6  00 1  0 1 1 0 0
1   0000 0200  200 200 0  608 401 4  00 0  0 0 0 0 0
40  0102 0200  160 200 2  608 441 4  00 0  0 0 0 0 0
9   0100 0200  151 200 2  608 448 4  00 0  0 0 0 0 0
248 0100 0300  0 200 2    608 200 0  00 0  0 0 0 0 0
1   0003 0000  0 200 2    608 200 0  00 0  0 0 0 0 0
13  0000 0000  0 200 2    608 200 0  00 0  0 0 0 0 0
1   0000 0000  0 200 2    608 200 0  00 1  0 1 6 32 216
575 0000 0000  0 200 2    608 200 0  00 1  0 1 6 607 216
1   0000 0000  0 200 2    608 200 0  10 0  0 0 0 0 0
1   0000 0000  0 200 2    608 200 0  00 0  0 0 0 0 0
14  0003 0003  0 200 2    608 200 0  00 0  0 0 0 0 0
1   0003 0003  0 200 2    608 200 0  00 1  0 1 0 624 199
1   0003 0003  0 200 2    608 200 0  00 2  1 1 6 32 216
15  0003 0003  0 200 2    608 200 0  00 3  2 1 0 624 199
33  0003 0003  0 200 2    608 200 0  00 8  7 1 6 32 216
25  0003 0003  0 200 2    608 200 0  00 8  0 1 0 624 125
